// ==== Makefile ====
VERILATOR ?= verilator
FLAGS := --binary --timing --assert -j 0
TOP := tb_layer_ctrl
FILELIST := sim.f
BUILD_DIR := obj_dir
LOG := sim.log
FAIL_MSG := Regression failed
SHELL := /bin/bash

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_layer_ctrl.sv ====
`timescale 1ns/100ps

module tb_layer_ctrl;

	localparam int RESET_CLOCKS = 10;
	localparam int ROTATE_CLOCKS = 5 * layer_ctrl_pkg::CPC; // Five full training cycles
	localparam int RANDOM_CLOCKS = 4 * layer_ctrl_pkg::CPC;
	localparam int STALL_CLOCKS = 200;
	localparam int DRAIN_CLOCKS = 4; // Lets the last items leave the pipeline
	localparam int TIMEOUT_NS = (RESET_CLOCKS + ROTATE_CLOCKS + RANDOM_CLOCKS + STALL_CLOCKS +
		DRAIN_CLOCKS + 50) * 10;

	// Both output buses side by side, so one compare covers a whole clock
	typedef struct packed {
		layer_ctrl_pkg::am_ctrl_t am;
		layer_ctrl_pkg::dm_ctrl_t dm;
	} ctrl_t;

	logic clk;
	logic rst_n;
	logic run;
	layer_ctrl_pkg::mem_index_t mem_index;
	layer_ctrl_pkg::lane_data_t act_data;
	layer_ctrl_pkg::lane_data_t sp_data;
	layer_ctrl_pkg::am_ctrl_t am_ctrl;
	layer_ctrl_pkg::dm_ctrl_t dm_ctrl;

	layer_ctrl_pkg::seq_t cur_item; // Model of the item the sequencer holds now
	layer_ctrl_pkg::seq_t d1_item; // One clock older
	layer_ctrl_pkg::seq_t d2_item; // Two clocks older
	layer_ctrl_pkg::mem_index_t idx_d1; // Interleaver index of the previous clock
	logic [layer_ctrl_pkg::CI_W-1:0] ci; // Model cycle counter
	logic [layer_ctrl_pkg::PT_W-1:0] rff;
	logic d_pt;
	ctrl_t exp_out;
	ctrl_t act_out;
	logic chk_addr; // Addresses and data are only defined once reset is released
	logic model_ready;
	int errors;
	int checks;
	string phase;
	int stall_left;
	int stretch;
	logic level;

	layer_ctrl_top layer_ctrl_top_inst (
		.clk(clk),
		.rst_n_i(rst_n),
		.run_i(run),
		.mem_index_i(mem_index),
		.act_data_i(act_data),
		.sp_data_i(sp_data),
		.am_ctrl_o(am_ctrl),
		.dm_ctrl_o(dm_ctrl)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Collection pointer k roles ahead, wrapping over the three collections
	function automatic logic [layer_ctrl_pkg::PT_W-1:0] pt_step(
		input logic [layer_ctrl_pkg::PT_W-1:0] pt, input int k);
		return layer_ctrl_pkg::PT_W'((int'(pt) + k) % layer_ctrl_pkg::COLLECTIONS);
	endfunction

	// Expected registered controls from the current item, its two predecessors and the inputs
	function automatic ctrl_t expected_outputs(input layer_ctrl_pkg::seq_t cur,
		input layer_ctrl_pkg::seq_t d1, input layer_ctrl_pkg::seq_t d2,
		input layer_ctrl_pkg::mem_index_t idx, input layer_ctrl_pkg::mem_index_t idx_prev,
		input layer_ctrl_pkg::lane_data_t act, input layer_ctrl_pkg::lane_data_t sp);
		ctrl_t e;
		int part_lanes;
		e = '0;
		part_lanes = layer_ctrl_pkg::Z / layer_ctrl_pkg::FO;
		for (int c = 0; c < layer_ctrl_pkg::COLLECTIONS; c++)
		begin
			for (int lane = 0; lane < layer_ctrl_pkg::Z; lane++)
			begin
				if (int'(d2.wff_pt) == c)
				begin
					e.am.addr[c][lane] = layer_ctrl_pkg::ADDR_W'(d2.ci / layer_ctrl_pkg::FO);
					e.am.we[c][lane] = d2.valid && d2.ci < layer_ctrl_pkg::WRITE_CLOCKS &&
						lane / part_lanes == d2.ci % layer_ctrl_pkg::FO; // One part per clock
				end
				else
					e.am.addr[c][lane] = layer_ctrl_pkg::ADDR_W'(idx[lane] / layer_ctrl_pkg::Z);
			end
		end
		e.am.rff_pt = cur.rff_pt;
		e.am.rup_pt = cur.rup_pt;
		e.am.act_data = act;
		e.am.sp_data = sp;
		for (int c = 0; c < 2; c++)
		begin
			for (int lane = 0; lane < layer_ctrl_pkg::Z; lane++)
			begin
				if (int'(cur.d_pt) == c)
				begin
					// Sequential read on A, the cell read last clock is cleared on B
					e.dm.addr_a[c][lane] =
						layer_ctrl_pkg::ADDR_W'(cur.ci / layer_ctrl_pkg::FO);
					e.dm.addr_b[c][lane] =
						layer_ctrl_pkg::ADDR_W'(d1.ci / layer_ctrl_pkg::FO);
				end
				else
				begin
					e.dm.addr_a[c][lane] =
						layer_ctrl_pkg::ADDR_W'(idx_prev[lane] / layer_ctrl_pkg::Z);
					e.dm.addr_b[c][lane] =
						layer_ctrl_pkg::ADDR_W'(idx[lane] / layer_ctrl_pkg::Z);
					e.dm.we_a[c][lane] = cur.valid && cur.ci >= 1 &&
						cur.ci <= layer_ctrl_pkg::WRITE_CLOCKS;
				end
				e.dm.we_b[c][lane] = int'(d1.d_pt) == c && d1.valid &&
					d1.ci < layer_ctrl_pkg::WRITE_CLOCKS &&
					lane / part_lanes == d1.ci % layer_ctrl_pkg::FO;
			end
		end
		e.dm.d_pt = cur.d_pt;
		return e;
	endfunction

	task automatic check(input string name, input logic [255:0] exp_v, input logic [255:0] act_v);
		checks++;
		if (act_v !== exp_v)
		begin
			errors++;
			$display("Mismatch %s: expected %0h, actual %0h", name, exp_v, act_v);
		end
	endtask

	// Inputs change 1 ns after the edge so the DUT samples settled values
	task automatic drive_clock(input logic run_lvl);
		@(posedge clk);
		#1;
		run = run_lvl;
		mem_index = layer_ctrl_pkg::mem_index_t'($urandom());
		act_data = $urandom();
		sp_data = $urandom();
	endtask

	// Reference model of the issued items, stepped on the same edge as the DUT
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			exp_out = '0;
			exp_out.am.rup_pt = 2; // Reset pointers 0, 1, 2 and delta 0
			chk_addr = 1'b0;
			cur_item = '0;
			cur_item.wff_pt = 1;
			cur_item.rup_pt = 2;
			d1_item = '0; // The delay lines clear to zero
			d2_item = '0;
			idx_d1 = '0;
			ci = '0;
			rff = '0;
			d_pt = 1'b0;
		end
		else
		begin
			exp_out = expected_outputs(cur_item, d1_item, d2_item, mem_index, idx_d1,
				act_data, sp_data);
			chk_addr = 1'b1;
			d2_item = d1_item;
			d1_item = cur_item;
			cur_item.valid = run;
			cur_item.ci = ci;
			cur_item.rff_pt = rff;
			cur_item.wff_pt = pt_step(rff, 1);
			cur_item.rup_pt = pt_step(rff, 2);
			cur_item.d_pt = d_pt;
			idx_d1 = mem_index;
			if (run && int'(ci) == layer_ctrl_pkg::CPC - 1)
			begin
				ci = '0; // Wrap moves every role one collection on
				rff = pt_step(rff, 1);
				d_pt = ~d_pt;
			end
			else if (run)
				ci = ci + 1'b1;
		end
		model_ready = 1'b1;
	end

	// Outputs are settled half a clock after the edge
	always @(negedge clk)
	begin
		if (model_ready)
		begin
			act_out.am = am_ctrl;
			act_out.dm = dm_ctrl;
			if (!chk_addr)
			begin
				act_out.am.addr = '0; // Address registers have no reset
				act_out.am.act_data = '0;
				act_out.am.sp_data = '0;
				act_out.dm.addr_a = '0;
				act_out.dm.addr_b = '0;
			end
			check({phase, " am_ctrl"}, 256'(exp_out.am), 256'(act_out.am));
			check({phase, " dm_ctrl"}, 256'(exp_out.dm), 256'(act_out.dm));
		end
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("Watchdog expired before all tests finished");
		$display("Regression failed");
		$finish;
	end

	initial
	begin
		void'($urandom(32'h00caaa0e));
		errors = 0;
		checks = 0;
		model_ready = 1'b0;
		phase = "reset";
		rst_n = 1'b0;
		run = 1'b0;
		mem_index = '0;
		act_data = '0;
		sp_data = '0;
		repeat (RESET_CLOCKS) drive_clock(1'b0);
		rst_n = 1'b1;
		phase = "rotation";
		repeat (ROTATE_CLOCKS) drive_clock(1'b1);
		phase = "random";
		repeat (RANDOM_CLOCKS) drive_clock(1'b1);
		phase = "stall"; // Alternating stretches of run low and high
		stall_left = STALL_CLOCKS;
		level = 1'b0;
		while (stall_left > 0)
		begin
			stretch = $urandom_range(7, 1);
			while (stretch > 0 && stall_left > 0)
			begin
				drive_clock(level);
				stretch--;
				stall_left--;
			end
			level = ~level;
		end
		phase = "drain";
		repeat (DRAIN_CLOCKS) drive_clock(1'b0);
		@(negedge clk);
		#1; // The compare of this last edge has run by now
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== hw/act_mem_ctrl.sv ====
`timescale 1ns/100ps

module act_mem_ctrl (
	input logic clk,
	input logic rst_n_i,
	input layer_ctrl_pkg::seq_t rd_seq_i, // Current item, drives the read side
	input layer_ctrl_pkg::seq_t wr_seq_i, // Item issued two clocks earlier, drives the writes
	input layer_ctrl_pkg::mem_index_t mem_index_i,
	input layer_ctrl_pkg::lane_data_t act_data_i, // Activations from this layer's FF
	input layer_ctrl_pkg::lane_data_t sp_data_i, // Matching sigmoid-prime values
	output layer_ctrl_pkg::am_ctrl_t am_ctrl_o
);

	layer_ctrl_pkg::addr_lanes_t rd_addr; // Interleaved read cells for FF and UP
	layer_ctrl_pkg::addr_lanes_t wr_addr; // Sequential write cell, same for all lanes
	logic [layer_ctrl_pkg::Z-1:0] wr_lanes; // Lanes of the part written this clock
	layer_ctrl_pkg::addr_lanes_t [layer_ctrl_pkg::COLLECTIONS-1:0] addr_d;
	logic [layer_ctrl_pkg::COLLECTIONS-1:0][layer_ctrl_pkg::Z-1:0] we_d;

	layer_ctrl_pkg::addr_lanes_t [layer_ctrl_pkg::COLLECTIONS-1:0] addr_q;
	logic [layer_ctrl_pkg::COLLECTIONS-1:0][layer_ctrl_pkg::Z-1:0] we_q;
	logic [layer_ctrl_pkg::PT_W-1:0] rff_q;
	logic [layer_ctrl_pkg::PT_W-1:0] rup_q;
	layer_ctrl_pkg::lane_data_t act_q;
	layer_ctrl_pkg::lane_data_t sp_q;
	logic [layer_ctrl_pkg::COLLECTIONS-1:0] coll_we; // Any lane of a collection writing

	assign rd_addr = layer_ctrl_pkg::decode_addr(mem_index_i);
	assign wr_addr = layer_ctrl_pkg::seq_addr_lanes(wr_seq_i.ci);
	assign wr_lanes = wr_seq_i.valid ? layer_ctrl_pkg::part_we(wr_seq_i.ci) : '0;

	// Only the FF write collection takes the write address, reads are not destructive
	always_comb
	begin
		for (int c = 0; c < layer_ctrl_pkg::COLLECTIONS; c++)
		begin
			if (wr_seq_i.wff_pt == layer_ctrl_pkg::PT_W'(c))
			begin
				addr_d[c] = wr_addr;
				we_d[c] = wr_lanes; // Uses the pointer of the write item's own cycle
			end
			else
			begin
				addr_d[c] = rd_addr;
				we_d[c] = '0;
			end
		end
	end

	// Enables and pointers
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			we_q <= '0;
			rff_q <= '0;
			rup_q <= layer_ctrl_pkg::PT_W'(2); // Two collections ahead of rff
		end
		else
		begin
			we_q <= we_d;
			rff_q <= rd_seq_i.rff_pt;
			rup_q <= rd_seq_i.rup_pt;
		end
	end

	// Addresses and write words
	always_ff @(posedge clk)
	begin
		addr_q <= addr_d;
		act_q <= act_data_i;
		sp_q <= sp_data_i;
	end

	always_comb
	begin
		am_ctrl_o.addr = addr_q;
		am_ctrl_o.we = we_q;
		am_ctrl_o.rff_pt = rff_q;
		am_ctrl_o.rup_pt = rup_q;
		am_ctrl_o.act_data = act_q;
		am_ctrl_o.sp_data = sp_q;
	end

	always_comb
	begin
		for (int c = 0; c < layer_ctrl_pkg::COLLECTIONS; c++)
		begin
			coll_we[c] = |we_q[c];
		end
	end

	// At most one collection is written in any clock
	we_one_coll: assert property (@(posedge clk) disable iff (!rst_n_i)
		$onehot0(coll_we));

	// A delayed write never lands on a collection the current item reads
	we_not_read: assert property (@(posedge clk) disable iff (!rst_n_i)
		(|coll_we) |-> !coll_we[rff_q] && !coll_we[rup_q]);

endmodule

// ==== hw/cycle_sequencer.sv ====
`timescale 1ns/100ps

module cycle_sequencer (
	input logic clk,
	input logic rst_n_i,
	input logic run_i, // Level enable, the count holds while low
	output layer_ctrl_pkg::seq_t seq_o
);

	logic [layer_ctrl_pkg::CI_W-1:0] ci_q; // Index of the next clock to issue
	logic [layer_ctrl_pkg::PT_W-1:0] rff_q;
	logic [layer_ctrl_pkg::PT_W-1:0] wff; // Always one collection after rff
	logic [layer_ctrl_pkg::PT_W-1:0] rup; // And rup one more after that
	logic d_q;
	logic wrap; // Last clock of the cycle is being issued

	// Step a collection pointer modulo the number of collections
	function automatic logic [layer_ctrl_pkg::PT_W-1:0] next_pt(
		input logic [layer_ctrl_pkg::PT_W-1:0] pt
	);
		if (pt == layer_ctrl_pkg::PT_W'(layer_ctrl_pkg::COLLECTIONS - 1))
			return '0;
		return pt + 1'b1;
	endfunction

	assign wrap = run_i && (ci_q == layer_ctrl_pkg::CI_W'(layer_ctrl_pkg::CPC - 1));
	assign wff = next_pt(rff_q);
	assign rup = next_pt(wff);

	// Cycle counter, with the pointers moving only when the count wraps
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			ci_q <= '0;
			rff_q <= '0;
			d_q <= 1'b0;
		end
		else if (run_i)
		begin
			ci_q <= wrap ? '0 : ci_q + 1'b1;
			if (wrap)
			begin
				rff_q <= next_pt(rff_q); // All three activation roles rotate together
				d_q <= ~d_q; // Delta collections ping-pong
			end
		end
	end

	// Issue register, the first pipeline stage of the controller
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			seq_o.valid <= 1'b0;
			seq_o.ci <= '0;
			seq_o.rff_pt <= '0;
			seq_o.wff_pt <= next_pt('0);
			seq_o.rup_pt <= next_pt(next_pt('0));
			seq_o.d_pt <= 1'b0;
		end
		else
		begin
			seq_o.valid <= run_i; // A stalled clock still carries the held count
			seq_o.ci <= ci_q;
			seq_o.rff_pt <= rff_q;
			seq_o.wff_pt <= wff;
			seq_o.rup_pt <= rup;
			seq_o.d_pt <= d_q;
		end
	end

	// The three roles must always land on different collections
	pt_distinct: assert property (@(posedge clk) disable iff (!rst_n_i)
		seq_o.rff_pt != seq_o.wff_pt && seq_o.wff_pt != seq_o.rup_pt &&
		seq_o.rff_pt != seq_o.rup_pt);

	ci_range: assert property (@(posedge clk) disable iff (!rst_n_i)
		seq_o.ci <= layer_ctrl_pkg::CI_W'(layer_ctrl_pkg::CPC - 1));

endmodule

// ==== hw/delay_line.sv ====
`timescale 1ns/100ps

module delay_line #(
	parameter type T = logic, // Payload carried through the chain
	parameter int DEPTH = 1 // Clocks of delay
) (
	input logic clk,
	input logic rst_n_i,
	input T d_i,
	output T q_o
);

	T stage_q [DEPTH]; // stage_q[0] is the youngest entry

	if (DEPTH < 1)
	begin : g_depth_check
		$error("delay_line needs a DEPTH of one or more");
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < DEPTH; i++)
			begin
				stage_q[i] <= '0; // Cleared items are invalid and carry zero pointers
			end
		end
		else
		begin
			stage_q[0] <= d_i;
			for (int i = 1; i < DEPTH; i++)
			begin
				stage_q[i] <= stage_q[i - 1]; // Shift one step toward the output
			end
		end
	end

	assign q_o = stage_q[DEPTH - 1];

endmodule

// ==== hw/delta_mem_ctrl.sv ====
`timescale 1ns/100ps

module delta_mem_ctrl (
	input logic clk,
	input logic rst_n_i,
	input layer_ctrl_pkg::seq_t seq_i, // Current item
	input layer_ctrl_pkg::seq_t seq_d1_i, // Item issued one clock earlier
	input layer_ctrl_pkg::mem_index_t mem_index_i,
	output layer_ctrl_pkg::dm_ctrl_t dm_ctrl_o
);

	layer_ctrl_pkg::mem_index_t mem_index_d1;
	layer_ctrl_pkg::addr_lanes_t il_addr; // Read cell of the RMW collection
	layer_ctrl_pkg::addr_lanes_t il_addr_d1; // Same cell, written back a clock later
	layer_ctrl_pkg::addr_lanes_t sq_addr; // Sequential read for BP of the previous layer
	layer_ctrl_pkg::addr_lanes_t sq_addr_d1; // Cell cleared after it was read
	logic [layer_ctrl_pkg::Z-1:0] clr_lanes;
	logic wr_window; // Clocks where a read from the last clock is written back
	layer_ctrl_pkg::addr_lanes_t [1:0] addr_a_d;
	layer_ctrl_pkg::addr_lanes_t [1:0] addr_b_d;
	logic [1:0][layer_ctrl_pkg::Z-1:0] we_a_d;
	logic [1:0][layer_ctrl_pkg::Z-1:0] we_b_d;

	layer_ctrl_pkg::addr_lanes_t [1:0] addr_a_q;
	layer_ctrl_pkg::addr_lanes_t [1:0] addr_b_q;
	logic [1:0][layer_ctrl_pkg::Z-1:0] we_a_q;
	logic [1:0][layer_ctrl_pkg::Z-1:0] we_b_q;
	logic d_pt_q;

	delay_line #(
		.T(layer_ctrl_pkg::mem_index_t),
		.DEPTH(1)
	) mem_index_dly_inst (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.d_i(mem_index_i),
		.q_o(mem_index_d1)
	);

	assign il_addr = layer_ctrl_pkg::decode_addr(mem_index_i);
	assign il_addr_d1 = layer_ctrl_pkg::decode_addr(mem_index_d1);
	assign sq_addr = layer_ctrl_pkg::seq_addr_lanes(seq_i.ci);
	assign sq_addr_d1 = layer_ctrl_pkg::seq_addr_lanes(seq_d1_i.ci);
	assign clr_lanes = seq_d1_i.valid ? layer_ctrl_pkg::part_we(seq_d1_i.ci) : '0;
	assign wr_window = seq_i.valid && (seq_i.ci >= 1) &&
		(seq_i.ci <= layer_ctrl_pkg::WRITE_CLOCKS);

	always_comb
	begin
		for (int c = 0; c < 2; c++)
		begin
			if (seq_i.d_pt == 1'(c))
			begin
				// BP read collection: A reads in order, B zeroes it for the next cycle
				addr_a_d[c] = sq_addr;
				addr_b_d[c] = sq_addr_d1;
				we_a_d[c] = '0;
			end
			else
			begin
				// RMW collection: B reads partial deltas, A writes the sums back
				addr_a_d[c] = il_addr_d1;
				addr_b_d[c] = il_addr;
				we_a_d[c] = {layer_ctrl_pkg::Z{wr_window}};
			end
			we_b_d[c] = (seq_d1_i.d_pt == 1'(c)) ? clr_lanes : '0; // Part by part
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			we_a_q <= '0;
			we_b_q <= '0;
			d_pt_q <= 1'b0;
		end
		else
		begin
			we_a_q <= we_a_d;
			we_b_q <= we_b_d;
			d_pt_q <= seq_i.d_pt;
		end
	end

	always_ff @(posedge clk)
	begin
		addr_a_q <= addr_a_d;
		addr_b_q <= addr_b_d;
	end

	always_comb
	begin
		dm_ctrl_o.addr_a = addr_a_q;
		dm_ctrl_o.addr_b = addr_b_q;
		dm_ctrl_o.we_a = we_a_q;
		dm_ctrl_o.we_b = we_b_q;
		dm_ctrl_o.d_pt = d_pt_q;
	end

	// Port A of the BP read collection only ever reads
	wea_read_coll: assert property (@(posedge clk) disable iff (!rst_n_i)
		we_a_q[d_pt_q] == '0);

	// The clear from the delayed item never meets a write-back on the same collection
	port_conflict: assert property (@(posedge clk) disable iff (!rst_n_i)
		(we_a_q[0] & we_b_q[0]) == '0 && (we_a_q[1] & we_b_q[1]) == '0);

endmodule

// ==== hw/layer_ctrl_pkg.sv ====
package layer_ctrl_pkg;

	localparam int P = 16; // Neurons in this hidden layer
	localparam int Z = 4; // Memories accessed in parallel, one per lane
	localparam int FO = 2; // Fan-out, so a collection splits into FO parts
	localparam int L = 3; // Layer count of the network
	localparam int H = 1; // Index of this layer, the one after the input layer
	localparam int WIDTH = 16; // Data word width
	localparam int COLLECTIONS = 2 * (L - H) - 1; // Activation and sigmoid-prime collections
	localparam int CPC = P / Z * FO + 2; // Clocks per training cycle, two spare for the pipeline
	localparam int WRITE_CLOCKS = P / Z * FO; // Active clocks of a cycle
	localparam int ADDR_W = $clog2(P / Z); // Each memory holds P/Z cells
	localparam int IDX_W = $clog2(P);
	localparam int CI_W = $clog2(CPC);
	localparam int PT_W = $clog2(COLLECTIONS);
	localparam int LANE_W = $clog2(Z); // Low index bits pick the lane, the rest are the cell
	localparam int PART_W = $clog2(FO);
	localparam int PART_LANES = Z / FO; // Memories in one part

	// One issued clock of a training cycle, tagged with the pointers of its own cycle
	typedef struct packed {
		logic valid;
		logic [CI_W-1:0] ci;
		logic [PT_W-1:0] rff_pt; // Read for feed-forward of the next layer
		logic [PT_W-1:0] wff_pt; // Written by feed-forward of this layer
		logic [PT_W-1:0] rup_pt; // Read for update, also the sigmoid-prime source of BP
		logic d_pt; // Delta collection read for BP of the previous layer
	} seq_t;

	typedef logic [Z-1:0][IDX_W-1:0] mem_index_t; // Neuron index per lane, from the interleaver
	typedef logic [PART_LANES-1:0][WIDTH-1:0] lane_data_t; // One cell of every memory in a part
	typedef logic [Z-1:0][ADDR_W-1:0] addr_lanes_t;

	typedef struct packed {
		addr_lanes_t [COLLECTIONS-1:0] addr;
		logic [COLLECTIONS-1:0][Z-1:0] we;
		logic [PT_W-1:0] rff_pt;
		logic [PT_W-1:0] rup_pt;
		lane_data_t act_data; // Same words go to every part of the write collection
		lane_data_t sp_data;
	} am_ctrl_t;

	// Delta memories are dual port and there are always two collections
	typedef struct packed {
		addr_lanes_t [1:0] addr_a;
		addr_lanes_t [1:0] addr_b;
		logic [1:0][Z-1:0] we_a;
		logic [1:0][Z-1:0] we_b;
		logic d_pt;
	} dm_ctrl_t;

	// Cell address of each lane is the neuron index without its lane bits
	function automatic addr_lanes_t decode_addr(input mem_index_t idx);
		addr_lanes_t addr;
		for (int lane = 0; lane < Z; lane++)
		begin
			addr[lane] = idx[lane][IDX_W-1:LANE_W];
		end
		return addr;
	endfunction

	// The cell stays the same for FO clocks while the parts take turns
	function automatic addr_lanes_t seq_addr_lanes(input logic [CI_W-1:0] ci);
		return {Z{ci[PART_W +: ADDR_W]}};
	endfunction

	// Lanes of the part addressed by this clock, empty past the active clocks
	function automatic logic [Z-1:0] part_we(input logic [CI_W-1:0] ci);
		logic [Z-1:0] we;
		we = '0;
		for (int lane = 0; lane < Z; lane++)
		begin
			we[lane] = (ci < WRITE_CLOCKS) && (lane / PART_LANES == int'(ci % FO));
		end
		return we;
	endfunction

endpackage

// ==== hw/layer_ctrl_top.sv ====
`timescale 1ns/100ps

module layer_ctrl_top (
	input logic clk,
	input logic rst_n_i,
	input logic run_i,
	input layer_ctrl_pkg::mem_index_t mem_index_i, // Interleaver output per lane
	input layer_ctrl_pkg::lane_data_t act_data_i,
	input layer_ctrl_pkg::lane_data_t sp_data_i,
	output layer_ctrl_pkg::am_ctrl_t am_ctrl_o, // Activation and sigmoid-prime memories
	output layer_ctrl_pkg::dm_ctrl_t dm_ctrl_o // Delta memories
);

	layer_ctrl_pkg::seq_t seq; // Item for the current clock
	layer_ctrl_pkg::seq_t seq_d1; // One clock older, for the delta RMW
	layer_ctrl_pkg::seq_t seq_d2; // Two clocks older, lines up with the FF results

	cycle_sequencer cycle_sequencer_inst (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.run_i(run_i),
		.seq_o(seq)
	);

	// The FF data for an item arrives two clocks after its reads
	delay_line #(
		.T(layer_ctrl_pkg::seq_t),
		.DEPTH(2)
	) seq_d2_inst (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.d_i(seq),
		.q_o(seq_d2)
	);

	delay_line #(
		.T(layer_ctrl_pkg::seq_t),
		.DEPTH(1)
	) seq_d1_inst (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.d_i(seq),
		.q_o(seq_d1)
	);

	act_mem_ctrl act_mem_ctrl_inst (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.rd_seq_i(seq),
		.wr_seq_i(seq_d2),
		.mem_index_i(mem_index_i),
		.act_data_i(act_data_i),
		.sp_data_i(sp_data_i),
		.am_ctrl_o(am_ctrl_o)
	);

	delta_mem_ctrl delta_mem_ctrl_inst (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.seq_i(seq),
		.seq_d1_i(seq_d1),
		.mem_index_i(mem_index_i),
		.dm_ctrl_o(dm_ctrl_o)
	);

endmodule

// ==== sim.f ====
hw/layer_ctrl_pkg.sv
hw/cycle_sequencer.sv
hw/delay_line.sv
hw/act_mem_ctrl.sv
hw/delta_mem_ctrl.sv
hw/layer_ctrl_top.sv
bench/tb_layer_ctrl.sv
